// ==== flist.f ====
rtl/cpu_pkg.sv
rtl/mem_bus_if.sv
rtl/wait_timer.sv
rtl/unified_ram.sv
rtl/reg_file.sv
rtl/out_credit_port.sv
rtl/instr_sequencer.sv
rtl/cpu_top.sv
tests/cpu_checker.sv
tests/tb_cpu_top.sv

// ==== Makefile ====
TOP = tb_cpu_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^\*\*\* TEST PASSED \*\*\*$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/tb_cpu_top.sv ====
// Testbench for the processor subsystem that runs random programs against a reference model.
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

    localparam int ADDR_W      = 8;
    localparam int WAIT_STATES = 2;
    localparam int CREDITS     = 4;
    localparam int PROG_LEN    = 24;
    localparam int DATA_BASE   = 64;  // data words live at 64 to 127.
    localparam int HALT_LIMIT  = 5000;
    localparam int QUIET       = 100;

    logic               clk;
    logic               rst;
    logic               load_en;
    logic [ADDR_W-1:0]  load_addr;
    logic [INSTR_W-1:0] load_data;
    logic               credit_return = 1'b0;
    logic               out_valid;
    logic [DATA_W-1:0]  out_data;
    logic               halted;

    logic [INSTR_W-1:0] model_mem [2**ADDR_W];
    logic [DATA_W-1:0]  exp_bytes [PROG_LEN];
    int                 exp_len;
    int                 rx_count;
    int                 errors;
    integer             seed = 32'haba8cc63;
    logic               give_credit;
    int                 held;
    int                 delay_left;
    int                 run_cycles;
    int                 hold_cycles;
    int                 delay_max;
    int                 tests_run;
    int                 tests_failed;
    int                 total_errors;

    cpu_top #(
        .ADDR_W      (ADDR_W),
        .WAIT_STATES (WAIT_STATES),
        .CREDITS     (CREDITS)
    ) i_cpu_top (.*);

    cpu_checker #(
        .CREDITS   (CREDITS),
        .EXP_DEPTH (PROG_LEN)
    ) i_cpu_checker (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // The consumer decides at the rising edge and returns the credit in the next cycle.
    always @(posedge clk) begin
        if (rst) begin
            held        = 0;
            delay_left  = 0;
            run_cycles  = 0;
            give_credit = 1'b0;
        end else begin
            held = held + int'(out_valid) - int'(give_credit);
            run_cycles++;
            give_credit = 1'b0;
            if (delay_left > 0) begin
                delay_left--;
            end else if (held > 0 && run_cycles > hold_cycles) begin
                give_credit = 1'b1;
                delay_left  = rand_below(delay_max + 1);
            end
        end
    end

    always @(negedge clk)
        credit_return = give_credit;

    task automatic gen_program(input int mode, input bit unknown_end);
        opcode_t           ops [4] = '{OUT, LI, OUTR, OUTLOC};
        opcode_t           op;
        logic [DATA_W-1:0] operand;
        for (int a = 0; a < PROG_LEN; a++) begin
            case (mode)
                0:       op = ops[rand_below(3)];
                1:       op = ops[3 * rand_below(2)];
                default: op = ops[rand_below(4)];
            endcase
            operand = DATA_W'(rand_below(256));
            if (op == OUTLOC)
                operand[DATA_W-1] = 1'b1; // word address lands in the data area.
            model_mem[a] = {REG_SEL_W'(rand_below(16)), op, operand};
        end
        // the instructions behind the stop must never run.
        model_mem[PROG_LEN-4][DATA_W +: OPCODE_W] =
            unknown_end ? OPCODE_W'(5 + rand_below(11)) : OPCODE_W'(HALT);
        for (int a = DATA_BASE; a < 2 * DATA_BASE; a++)
            model_mem[a] = INSTR_W'(rand_below(65536));
    endtask

    task automatic run_model();
        logic [DATA_W-1:0]  regs [2**REG_SEL_W];
        logic [INSTR_W-1:0] word;
        logic [DATA_W-1:0]  operand;
        logic [DATA_W-1:0]  out_byte;
        bit                 has_out;
        bit                 running;
        int                 pc;
        for (int i = 0; i < 2**REG_SEL_W; i++)
            regs[i] = '0;
        exp_len = 0;
        pc      = 0;
        running = 1'b1;
        while (running) begin
            word    = model_mem[pc];
            operand = word[DATA_W-1:0];
            has_out = 1'b1;
            case (word[DATA_W +: OPCODE_W])
                OUT:    out_byte = operand;
                OUTLOC: out_byte = model_mem[operand >> 1][DATA_W-1:0];
                OUTR:   out_byte = regs[word[INSTR_W-1 -: REG_SEL_W]];
                LI: begin
                    regs[word[INSTR_W-1 -: REG_SEL_W]] = operand;
                    has_out = 1'b0;
                end
                default: begin
                    running = 1'b0;  // HALT and every unknown opcode stop the program.
                    has_out = 1'b0;
                end
            endcase
            if (has_out) begin
                exp_bytes[exp_len] = out_byte;
                exp_len++;
            end
            pc++;
        end
    endtask

    task automatic run_test(input string name, input int mode, input bit unknown_end,
                            input int hold, input int max_delay);
        int cycles;
        int test_errors;
        @(negedge clk);
        rst = 1'b1;
        gen_program(mode, unknown_end);
        run_model();
        for (int a = 0; a < 2 * DATA_BASE; a++) begin
            if (a < PROG_LEN || a >= DATA_BASE) begin
                @(negedge clk);
                load_en   = 1'b1;
                load_addr = ADDR_W'(a);
                load_data = model_mem[a];
            end
        end
        @(negedge clk);
        load_en = 1'b0;
        repeat (5) @(negedge clk);
        hold_cycles = hold;
        delay_max   = max_delay;
        rst         = 1'b0;
        test_errors = 0;
        @(negedge clk);
        if (out_valid || halted) begin
            $display("CHECK FAILED at %0t: %s, output active right after reset", $time, name);
            test_errors++;
        end
        cycles = 0;
        while (!halted && cycles < HALT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("ERROR: %s timed out, the processor did not halt within %0d cycles",
                     name, HALT_LIMIT);
            test_errors++;
        end
        for (int i = 0; i < QUIET; i++)
            @(negedge clk);  // the checker flags any byte in this window.
        if (rx_count != exp_len) begin
            $display("CHECK FAILED at %0t: %s, %0d bytes received, %0d expected",
                     $time, name, rx_count, exp_len);
            test_errors++;
        end
        test_errors += errors;
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        total_errors += test_errors;
        $display("test %0d %s: %0d of %0d bytes, %0d errors",
                 tests_run, name, rx_count, exp_len, test_errors);
    endtask

    initial begin
        rst          = 1'b1;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        exp_len      = 0;
        hold_cycles  = 0;
        delay_max    = 0;
        tests_run    = 0;
        tests_failed = 0;
        total_errors = 0;
        run_test("out_outr_li", 0, 1'b0, 0, 3);
        run_test("outloc", 1, 1'b0, 0, 3);
        run_test("unknown_opcode", 2, 1'b1, 0, 3);
        run_test("credit_stall", 2, 1'b0, 300, 1);
        for (int t = 0; t < 3; t++)
            run_test("random_program", 2, t[0], 0, 6);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
        if (total_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/cpu_checker.sv ====
// Output checker that compares the DUT byte stream with the expected bytes and tracks credits.
`timescale 1ns/1ps
`default_nettype none

module cpu_checker import cpu_pkg::*; #(
    parameter int CREDITS   = 4,
    parameter int EXP_DEPTH = 24
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              out_valid,
    input  logic [DATA_W-1:0] out_data,
    input  logic              credit_return,
    input  logic              halted,
    input  logic [DATA_W-1:0] exp_bytes [EXP_DEPTH],
    input  int                exp_len,
    output int                rx_count,
    output int                errors
);

    int   outstanding;  // bytes taken by the consumer and not yet paid back.
    logic halt_seen;
    logic in_reset;

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            if (in_reset !== 1'b1)
                errors = 0;  // a fresh reset starts a new test.
            if (out_valid === 1'b1 || halted === 1'b1)
                report_error("out_valid or halted high during reset");
            in_reset    = 1'b1;
            rx_count    = 0;
            outstanding = 0;
            halt_seen   = 1'b0;
        end else begin
            in_reset = 1'b0;
            if (out_valid) begin
                if (halt_seen)
                    report_error($sformatf("byte %02h sent after halt", out_data));
                else if (rx_count >= exp_len)
                    report_error($sformatf("extra byte %02h, only %0d expected",
                                           out_data, exp_len));
                else if (out_data !== exp_bytes[rx_count])
                    report_error($sformatf("byte %0d is %02h, expected %02h",
                                           rx_count, out_data, exp_bytes[rx_count]));
                rx_count++;
            end
            outstanding = outstanding + int'(out_valid) - int'(credit_return);
            if (outstanding > CREDITS || outstanding < 0)
                report_error($sformatf("%0d bytes held by the consumer, limit is %0d",
                                       outstanding, CREDITS));
            if (halt_seen && !halted)
                report_error("halted fell without a reset");
            halt_seen = halt_seen || halted;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
// Processor subsystem top level joining sequencer, memory, registers and output port.
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter int ADDR_W      = 8,
    parameter int WAIT_STATES = 2,
    parameter int CREDITS     = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               load_en,
    input  logic [ADDR_W-1:0]  load_addr,
    input  logic [INSTR_W-1:0] load_data,
    input  logic               credit_return,
    output logic               out_valid,
    output logic [DATA_W-1:0]  out_data,
    output logic               halted
);

    logic                 rf_we;
    logic [REG_SEL_W-1:0] rf_wsel;
    logic [DATA_W-1:0]    rf_wdata;
    logic [REG_SEL_W-1:0] rf_rsel;
    logic [DATA_W-1:0]    rf_rdata;
    logic                 send;
    logic [DATA_W-1:0]    send_byte;
    logic                 has_credit;

    mem_bus_if #(
        .ADDR_W(ADDR_W)
    ) mem_bus ();

    instr_sequencer #(
        .ADDR_W(ADDR_W)
    ) i_instr_sequencer (
        .clk        (clk),
        .rst        (rst),
        .mem        (mem_bus.master),
        .rf_we      (rf_we),
        .rf_wsel    (rf_wsel),
        .rf_wdata   (rf_wdata),
        .rf_rsel    (rf_rsel),
        .rf_rdata   (rf_rdata),
        .send       (send),
        .send_byte  (send_byte),
        .has_credit (has_credit),
        .halted     (halted)
    );

    unified_ram #(
        .ADDR_W      (ADDR_W),
        .WAIT_STATES (WAIT_STATES)
    ) i_unified_ram (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .bus       (mem_bus.slave)
    );

    reg_file i_reg_file (
        .clk   (clk),
        .rst   (rst),
        .we    (rf_we),
        .wsel  (rf_wsel),
        .wdata (rf_wdata),
        .rsel  (rf_rsel),
        .rdata (rf_rdata)
    );

    out_credit_port #(
        .CREDITS(CREDITS)
    ) i_out_credit_port (
        .clk           (clk),
        .rst           (rst),
        .send          (send),
        .send_byte     (send_byte),
        .credit_return (credit_return),
        .has_credit    (has_credit),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

endmodule

`default_nettype wire

// ==== rtl/instr_sequencer.sv ====
// Instruction sequencer that fetches, decodes and executes the 16-bit instruction stream.
`timescale 1ns/1ps
`default_nettype none

module instr_sequencer import cpu_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    mem_bus_if.master            mem,
    output logic                 rf_we,
    output logic [REG_SEL_W-1:0] rf_wsel,
    output logic [DATA_W-1:0]    rf_wdata,
    output logic [REG_SEL_W-1:0] rf_rsel,
    input  logic [DATA_W-1:0]    rf_rdata,
    output logic                 send,
    output logic [DATA_W-1:0]    send_byte,
    input  logic                 has_credit,
    output logic                 halted
);

    seq_state_t          state;
    logic [ADDR_W-1:0]   pc;
    logic                data_rd;  // the pending request is an OUTLOC data read.
    logic [INSTR_W-1:0]  instr_q;
    logic [DATA_W-1:0]   byte_q;
    opcode_t             op_in;
    opcode_t             op_q;

    assign op_in = opcode_t'(mem.rdata[DATA_W +: OPCODE_W]);
    assign op_q  = opcode_t'(instr_q[DATA_W +: OPCODE_W]);

    // LI writes straight from the fetched word while ack is high.
    assign rf_we    = (state == AWAIT_INSTR) && mem.ack && (op_in == LI);
    assign rf_wsel  = mem.rdata[INSTR_W-1 -: REG_SEL_W];
    assign rf_wdata = mem.rdata[DATA_W-1:0];
    assign rf_rsel  = instr_q[INSTR_W-1 -: REG_SEL_W];

    assign send      = (state == WAIT_CREDIT) && has_credit;
    assign send_byte = (op_q == OUTR) ? rf_rdata : byte_q;
    assign halted    = (state == HALTED);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= FETCH;
            pc       <= '0;
            data_rd  <= 1'b0;
            mem.req  <= 1'b0;
            mem.addr <= '0;
        end else begin
            case (state)
                FETCH: begin
                    if (!mem.req) begin
                        mem.req  <= 1'b1;
                        mem.addr <= pc;
                    end else begin
                        mem.req <= 1'b0;
                        state   <= data_rd ? AWAIT_DATA : AWAIT_INSTR;
                    end
                end
                AWAIT_INSTR: begin
                    if (mem.ack) begin
                        case (op_in)
                            OUT, OUTR: state <= WAIT_CREDIT;
                            OUTLOC: begin
                                data_rd  <= 1'b1;
                                mem.req  <= 1'b1;
                                mem.addr <= ADDR_W'(mem.rdata[DATA_W-1:1]); // word address.
                                state    <= FETCH;
                            end
                            LI: begin
                                pc    <= pc + 1'b1;
                                state <= FETCH;
                            end
                            default: state <= HALTED; // HALT and every unknown opcode.
                        endcase
                    end
                end
                AWAIT_DATA: begin
                    if (mem.ack) begin
                        data_rd <= 1'b0;
                        state   <= WAIT_CREDIT;
                    end
                end
                WAIT_CREDIT: begin
                    if (has_credit) begin
                        pc       <= pc + 1'b1;
                        mem.req  <= 1'b1;  // next fetch goes out right behind the send.
                        mem.addr <= pc + 1'b1;
                        state    <= FETCH;
                    end
                end
                default: ;
            endcase
        end
    end

    // Operand of OUT or the low byte of an OUTLOC data word.
    always_ff @(posedge clk) begin
        if (state == AWAIT_INSTR && mem.ack) begin
            instr_q <= mem.rdata;
            byte_q  <= mem.rdata[DATA_W-1:0];
        end else if (state == AWAIT_DATA && mem.ack) begin
            byte_q <= mem.rdata[DATA_W-1:0];
        end
    end

    a_no_req_while_waiting: assert property (@(posedge clk) disable iff (rst)
        (state inside {AWAIT_INSTR, AWAIT_DATA}) |-> !mem.req);

    // An ack outside the wait states would be lost by the sequencer.
    a_ack_while_waiting: assert property (@(posedge clk) disable iff (rst)
        mem.ack |-> (state inside {AWAIT_INSTR, AWAIT_DATA}));

endmodule

`default_nettype wire

// ==== rtl/out_credit_port.sv ====
// Output byte port with credit-based flow control toward the external consumer.
`timescale 1ns/1ps
`default_nettype none

module out_credit_port import cpu_pkg::*; #(
    parameter int CREDITS = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              send,
    input  logic [DATA_W-1:0] send_byte,
    input  logic              credit_return,
    output logic              has_credit,
    output logic              out_valid,
    output logic [DATA_W-1:0] out_data
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;

    // A send and a returned credit in the same cycle cancel out.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit_cnt <= CNT_W'(CREDITS);
        end else begin
            case ({send, credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    assign has_credit = (credit_cnt != '0);
    assign out_valid  = send;
    assign out_data   = send_byte;

    a_cnt_in_range: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= CREDITS);

    // The consumer must not return more credits than it was given.
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (credit_return && !send) |-> (credit_cnt < CREDITS));

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        send |-> (credit_cnt != '0));

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
// General register file with sixteen byte registers, one write and one read port.
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 we,
    input  logic [REG_SEL_W-1:0] wsel,
    input  logic [DATA_W-1:0]    wdata,
    input  logic [REG_SEL_W-1:0] rsel,
    output logic [DATA_W-1:0]    rdata
);

    logic [DATA_W-1:0] regs [2**REG_SEL_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_SEL_W; i++) begin
                regs[i] <= '0; // unloaded registers read as zero.
            end
        end else if (we) begin
            regs[wsel] <= wdata;
        end
    end

    assign rdata = regs[rsel];

endmodule

`default_nettype wire

// ==== rtl/unified_ram.sv ====
// Unified program and data memory with a load port and wait-stated read acknowledges.
`timescale 1ns/1ps
`default_nettype none

module unified_ram import cpu_pkg::*; #(
    parameter int ADDR_W      = 8,
    parameter int WAIT_STATES = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               load_en,
    input  logic [ADDR_W-1:0]  load_addr,
    input  logic [INSTR_W-1:0] load_data,
    mem_bus_if.slave           bus
);

    logic [INSTR_W-1:0] mem [2**ADDR_W];
    logic [ADDR_W-1:0]  addr_q;
    logic               done;
    logic               busy;

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.req) begin
            addr_q <= bus.addr;
        end
    end

    wait_timer #(
        .WAIT_STATES(WAIT_STATES)
    ) i_wait_timer (
        .clk   (clk),
        .rst   (rst),
        .start (bus.req),
        .done  (done),
        .busy  (busy)
    );

    assign bus.ack   = done;
    assign bus.rdata = mem[addr_q]; // word stays put while the access is pending.

    // The master may only start a new access after the previous ack.
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        bus.req |-> !busy);

endmodule

`default_nettype wire

// ==== rtl/wait_timer.sv ====
// Wait state timer that pulses done a fixed number of cycles after start.
`timescale 1ns/1ps
`default_nettype none

module wait_timer #(
    parameter int WAIT_STATES = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic done,
    output logic busy
);

    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [CNT_W-1:0] count;
    logic             active;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            count  <= '0;
        end else if (start) begin
            active <= 1'b1;
            count  <= CNT_W'(WAIT_STATES);
        end else if (active) begin
            if (count == '0) begin
                active <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign done = active && (count == '0); // WAIT_STATES+1 cycles after start.
    assign busy = active;

endmodule

`default_nettype wire

// ==== rtl/mem_bus_if.sv ====
// Request and acknowledge bus between the sequencer and the unified memory.
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if import cpu_pkg::*; #(
    parameter int ADDR_W = 8
) ();

    logic                req;   // one-cycle pulse, at most one access in flight.
    logic [ADDR_W-1:0]   addr;  // held stable until ack.
    logic [INSTR_W-1:0]  rdata; // valid in the ack cycle.
    logic                ack;

    modport master (
        output req,
        output addr,
        input  rdata,
        input  ack
    );

    modport slave (
        input  req,
        input  addr,
        output rdata,
        output ack
    );

endinterface

`default_nettype wire

// ==== rtl/cpu_pkg.sv ====
// Shared instruction format, opcode and sequencer state definitions for the processor.
`default_nettype none

package cpu_pkg;

    localparam int INSTR_W   = 16;  // instruction and memory word width.
    localparam int DATA_W    = 8;   // register, operand and output byte width.
    localparam int REG_SEL_W = 4;
    localparam int OPCODE_W  = 4;

    // Instruction layout is {reg_sel, opcode, operand} from the top bit down.
    typedef enum logic [OPCODE_W-1:0] {
        HALT   = 4'd0,
        OUT    = 4'd1,
        OUTLOC = 4'd2,
        LI     = 4'd3,
        OUTR   = 4'd4
    } opcode_t;

    typedef enum logic [2:0] {
        FETCH,
        AWAIT_INSTR,
        AWAIT_DATA,
        WAIT_CREDIT,
        HALTED
    } seq_state_t;

endpackage

`default_nettype wire
